/* include/slink_macros.svh */
`ifndef SLINK_MACROS_SVH
`define SLINK_MACROS_SVH

// Link geometry
`define SLINK_NUM_LANES       4
`define SLINK_PHY_DATA_WIDTH  8
`define SLINK_LINK_WIDTH      (`SLINK_NUM_LANES * `SLINK_PHY_DATA_WIDTH)

// APB register map
`define SLINK_APB_ADDR_W      8
`define SLINK_REG_CTRL        8'h00
`define SLINK_REG_INT_EN      8'h04
`define SLINK_REG_INT_STATUS  8'h08
`define SLINK_REG_RX_COUNT    8'h0C
`define SLINK_REG_TX_COUNT    8'h10

// CRC-16 CCITT
`define SLINK_CRC_POLY        16'h1021
`define SLINK_CRC_INIT        16'hFFFF

`endif

/* logic/slink_ctrl_regs.sv */
`timescale 1ns/1ns
`include "slink_macros.svh"

module slink_ctrl_regs (
  input  logic                         link_clk,
  input  logic                         rst,
  input  logic [`SLINK_APB_ADDR_W-1:0] apb_paddr,
  input  logic                         apb_pwrite,
  input  logic                         apb_psel,
  input  logic                         apb_penable,
  input  logic [31:0]                  apb_pwdata,
  output logic [31:0]                  apb_prdata,
  output logic                         apb_pslverr,
  output logic                         interrupt,
  slink_status_if.regs                 status
);

  slink_pkg::int_bits_t  int_en;
  slink_pkg::int_bits_t  int_status;
  slink_pkg::int_bits_t  int_event;
  slink_pkg::int_bits_t  int_clear;
  slink_pkg::pkt_count_t rx_count;
  slink_pkg::pkt_count_t tx_count;

  logic access;
  logic wr;
  logic mapped;

  assign access = apb_psel && apb_penable;
  assign wr     = access && apb_pwrite;

  always_comb begin
    mapped = 1'b1;
    case (apb_paddr)
      `SLINK_REG_CTRL:       apb_prdata = {31'd0, status.ll_enable};
      `SLINK_REG_INT_EN:     apb_prdata = {29'd0, int_en};
      `SLINK_REG_INT_STATUS: apb_prdata = {29'd0, int_status};
      `SLINK_REG_RX_COUNT:   apb_prdata = {16'd0, rx_count};
      `SLINK_REG_TX_COUNT:   apb_prdata = {16'd0, tx_count};
      default: begin
        apb_prdata = '0;
        mapped     = 1'b0;
      end
    endcase
  end

  assign apb_pslverr = access && !mapped;

  //----------------------------------------------------------------------
  // Control and enables
  //----------------------------------------------------------------------
  always_ff @(posedge link_clk) begin
    if (rst) begin
      status.ll_enable <= 1'b0;
      int_en           <= '0;
    end else if (wr) begin
      if (apb_paddr == `SLINK_REG_CTRL) begin
        status.ll_enable <= apb_pwdata[0];
      end
      if (apb_paddr == `SLINK_REG_INT_EN) begin
        int_en <= apb_pwdata[2:0];
      end
    end
  end

  //----------------------------------------------------------------------
  // W1C status
  //----------------------------------------------------------------------
  always_comb begin
    int_event.pkt_received  = status.pkt_received;
    int_event.hdr_corrupted = status.hdr_corrupted;
    int_event.crc_corrupted = status.crc_corrupted;
  end

  assign int_clear = (wr && apb_paddr == `SLINK_REG_INT_STATUS) ? apb_pwdata[2:0] : '0;

  // New event wins over a clear in the same cycle
  always_ff @(posedge link_clk) begin
    if (rst) begin
      int_status <= '0;
    end else begin
      int_status <= int_event | (int_status & ~int_clear);
    end
  end

  assign interrupt = |(int_status & int_en);

  // Packet counters, wrapping
  always_ff @(posedge link_clk) begin
    if (rst) begin
      rx_count <= '0;
      tx_count <= '0;
    end else begin
      if (status.pkt_received) begin
        rx_count <= rx_count + 1'b1;
      end
      if (status.tx_pkt_sent) begin
        tx_count <= tx_count + 1'b1;
      end
    end
  end

endmodule

/* logic/slink_lite.sv */
`timescale 1ns/1ns
`include "slink_macros.svh"

module slink_lite (
  input  logic                         link_clk,
  input  logic                         rst,

  // APB
  input  logic [`SLINK_APB_ADDR_W-1:0] apb_paddr,
  input  logic                         apb_pwrite,
  input  logic                         apb_psel,
  input  logic                         apb_penable,
  input  logic [31:0]                  apb_pwdata,
  output logic [31:0]                  apb_prdata,
  output logic                         apb_pslverr,

  // TX application
  input  logic                         tx_sop,
  input  slink_pkg::data_id_t          tx_data_id,
  input  slink_pkg::word_count_t       tx_word_count,
  input  slink_pkg::link_word_t        tx_app_data,
  output logic                         tx_advance,

  // RX application
  output logic                         rx_sop,
  output slink_pkg::data_id_t          rx_data_id,
  output slink_pkg::word_count_t       rx_word_count,
  output slink_pkg::link_word_t        rx_app_data,
  output logic                         rx_valid,
  output logic                         rx_crc_corrupted,

  output logic                         interrupt,

  // PHY
  output slink_pkg::link_word_t        phy_tx_data,
  output logic                         phy_tx_valid,
  input  slink_pkg::link_word_t        phy_rx_data,
  input  logic                         phy_rx_valid
);

  slink_status_if u_status ();

  slink_ll_tx u_slink_ll_tx (
    .link_clk      ( link_clk      ),
    .rst           ( rst           ),
    .tx_sop        ( tx_sop        ),
    .tx_data_id    ( tx_data_id    ),
    .tx_word_count ( tx_word_count ),
    .tx_app_data   ( tx_app_data   ),
    .tx_advance    ( tx_advance    ),
    .phy_tx_data   ( phy_tx_data   ),
    .phy_tx_valid  ( phy_tx_valid  ),
    .status        ( u_status      )
  );

  slink_ctrl_regs u_slink_ctrl_regs (
    .link_clk    ( link_clk    ),
    .rst         ( rst         ),
    .apb_paddr   ( apb_paddr   ),
    .apb_pwrite  ( apb_pwrite  ),
    .apb_psel    ( apb_psel    ),
    .apb_penable ( apb_penable ),
    .apb_pwdata  ( apb_pwdata  ),
    .apb_prdata  ( apb_prdata  ),
    .apb_pslverr ( apb_pslverr ),
    .interrupt   ( interrupt   ),
    .status      ( u_status    )
  );

  slink_ll_rx u_slink_ll_rx (
    .link_clk         ( link_clk         ),
    .rst              ( rst              ),
    .phy_rx_data      ( phy_rx_data      ),
    .phy_rx_valid     ( phy_rx_valid     ),
    .rx_sop           ( rx_sop           ),
    .rx_data_id       ( rx_data_id       ),
    .rx_word_count    ( rx_word_count    ),
    .rx_app_data      ( rx_app_data      ),
    .rx_valid         ( rx_valid         ),
    .rx_crc_corrupted ( rx_crc_corrupted ),
    .status           ( u_status         )
  );

endmodule

/* logic/slink_ll_rx.sv */
`timescale 1ns/1ns
`include "slink_macros.svh"

module slink_ll_rx (
  input  logic                   link_clk,
  input  logic                   rst,
  input  slink_pkg::link_word_t  phy_rx_data,
  input  logic                   phy_rx_valid,
  output logic                   rx_sop,
  output slink_pkg::data_id_t    rx_data_id,
  output slink_pkg::word_count_t rx_word_count,
  output slink_pkg::link_word_t  rx_app_data,
  output logic                   rx_valid,
  output logic                   rx_crc_corrupted,
  slink_status_if.rx             status
);

  slink_pkg::rx_state_t   state;
  slink_pkg::word_count_t remaining;
  slink_pkg::crc_t        crc;

  slink_pkg::data_id_t    hdr_id;
  slink_pkg::word_count_t hdr_wc;
  logic [7:0]             hdr_chk;
  logic                   take;
  logic                   hdr_ok;
  logic                   crc_bad;

  // Header fields as they would sit in an incoming word
  assign hdr_id  = phy_rx_data[7:0];
  assign hdr_wc  = phy_rx_data[23:8];
  assign hdr_chk = phy_rx_data[31:24];

  assign take    = phy_rx_valid && status.ll_enable;
  assign hdr_ok  = (slink_pkg::hdr_check(hdr_id, hdr_wc) == hdr_chk);
  assign crc_bad = (phy_rx_data != {{(`SLINK_LINK_WIDTH-16){1'b0}}, crc});

  //----------------------------------------------------------------------
  // Hunt, payload count and CRC verdict
  //----------------------------------------------------------------------
  always_ff @(posedge link_clk) begin
    if (rst) begin
      state                <= slink_pkg::RX_HUNT;
      remaining            <= '0;
      rx_sop               <= 1'b0;
      rx_valid             <= 1'b0;
      rx_crc_corrupted     <= 1'b0;
      status.pkt_received  <= 1'b0;
      status.hdr_corrupted <= 1'b0;
      status.crc_corrupted <= 1'b0;
    end else begin
      rx_sop               <= 1'b0;
      rx_valid             <= 1'b0;
      rx_crc_corrupted     <= 1'b0;
      status.pkt_received  <= 1'b0;
      status.hdr_corrupted <= 1'b0;
      status.crc_corrupted <= 1'b0;
      if (take) begin
        case (state)
          slink_pkg::RX_HUNT: begin
            if (hdr_ok) begin
              rx_sop    <= 1'b1;
              remaining <= hdr_wc;
              state     <= (hdr_wc == '0) ? slink_pkg::RX_CRC : slink_pkg::RX_PAYLOAD;
            end else begin
              // Bad header is dropped and hunting goes on
              status.hdr_corrupted <= 1'b1;
            end
          end
          slink_pkg::RX_PAYLOAD: begin
            rx_valid  <= 1'b1;
            remaining <= remaining - 1'b1;
            if (remaining == 16'd1) begin
              state <= slink_pkg::RX_CRC;
            end
          end
          slink_pkg::RX_CRC: begin
            status.pkt_received  <= 1'b1;
            status.crc_corrupted <= crc_bad;
            rx_crc_corrupted     <= crc_bad;
            state                <= slink_pkg::RX_HUNT;
          end
          default: state <= slink_pkg::RX_HUNT;
        endcase
      end
    end
  end

  // Packet fields and running CRC
  always_ff @(posedge link_clk) begin
    if (take) begin
      case (state)
        slink_pkg::RX_HUNT: begin
          if (hdr_ok) begin
            rx_data_id    <= hdr_id;
            rx_word_count <= hdr_wc;
            crc           <= `SLINK_CRC_INIT;
          end
        end
        slink_pkg::RX_PAYLOAD: begin
          rx_app_data <= phy_rx_data;
          crc         <= slink_pkg::crc16_step(crc, phy_rx_data);
        end
        default: begin
        end
      endcase
    end
  end

endmodule

/* logic/slink_ll_tx.sv */
`timescale 1ns/1ns
`include "slink_macros.svh"

module slink_ll_tx (
  input  logic                   link_clk,
  input  logic                   rst,
  input  logic                   tx_sop,
  input  slink_pkg::data_id_t    tx_data_id,
  input  slink_pkg::word_count_t tx_word_count,
  input  slink_pkg::link_word_t  tx_app_data,
  output logic                   tx_advance,
  output slink_pkg::link_word_t  phy_tx_data,
  output logic                   phy_tx_valid,
  slink_status_if.tx             status
);

  slink_pkg::tx_state_t   state;
  slink_pkg::word_count_t remaining;
  slink_pkg::crc_t        crc;
  logic                   start;

  assign start = (state == slink_pkg::TX_IDLE) && tx_sop && status.ll_enable;

  // Header cycle already takes the first payload word
  assign tx_advance = ((state == slink_pkg::TX_HEADER) || (state == slink_pkg::TX_PAYLOAD)) &&
                      (remaining != '0);

  //----------------------------------------------------------------------
  // Frame sequencing
  //----------------------------------------------------------------------
  always_ff @(posedge link_clk) begin
    if (rst) begin
      state               <= slink_pkg::TX_IDLE;
      remaining           <= '0;
      phy_tx_valid        <= 1'b0;
      status.tx_pkt_sent  <= 1'b0;
    end else begin
      phy_tx_valid       <= 1'b0;
      status.tx_pkt_sent <= 1'b0;
      case (state)
        slink_pkg::TX_IDLE: begin
          if (start) begin
            state        <= slink_pkg::TX_HEADER;
            remaining    <= tx_word_count;
            phy_tx_valid <= 1'b1;
          end
        end
        slink_pkg::TX_HEADER, slink_pkg::TX_PAYLOAD: begin
          phy_tx_valid <= 1'b1;
          if (tx_advance) begin
            remaining <= remaining - 1'b1;
            state     <= (remaining == 16'd1) ? slink_pkg::TX_CRC : slink_pkg::TX_PAYLOAD;
          end else begin
            // Empty packet, CRC word right behind the header
            status.tx_pkt_sent <= 1'b1;
            state              <= slink_pkg::TX_IDLE;
          end
        end
        slink_pkg::TX_CRC: begin
          phy_tx_valid       <= 1'b1;
          status.tx_pkt_sent <= 1'b1;
          state              <= slink_pkg::TX_IDLE;
        end
        default: state <= slink_pkg::TX_IDLE;
      endcase
    end
  end

  //----------------------------------------------------------------------
  // Link word and running CRC
  //----------------------------------------------------------------------
  always_ff @(posedge link_clk) begin
    if (start) begin
      phy_tx_data <= {slink_pkg::hdr_check(tx_data_id, tx_word_count),
                      tx_word_count, tx_data_id};
      crc         <= `SLINK_CRC_INIT;
    end else if (tx_advance) begin
      phy_tx_data <= tx_app_data;
      crc         <= slink_pkg::crc16_step(crc, tx_app_data);
    end else if (state != slink_pkg::TX_IDLE) begin
      phy_tx_data <= {{(`SLINK_LINK_WIDTH-16){1'b0}}, crc};
    end
  end

endmodule

/* logic/slink_pkg.sv */
`include "slink_macros.svh"

package slink_pkg;

  typedef logic [`SLINK_LINK_WIDTH-1:0] link_word_t;
  typedef logic [7:0]                   data_id_t;
  typedef logic [15:0]                  word_count_t;
  typedef logic [15:0]                  crc_t;
  typedef logic [15:0]                  pkt_count_t;

  // First member is the MSB, so crc_corrupted lands on bit 0
  typedef struct packed {
    logic pkt_received;
    logic hdr_corrupted;
    logic crc_corrupted;
  } int_bits_t;

  typedef enum logic [1:0] {TX_IDLE, TX_HEADER, TX_PAYLOAD, TX_CRC} tx_state_t;
  typedef enum logic [1:0] {RX_HUNT, RX_PAYLOAD, RX_CRC} rx_state_t;

  // Bytes lowest first, MSB first within each byte
  function automatic crc_t crc16_step(input crc_t crc_in, input link_word_t word);
    crc_t crc;
    logic fb;
    crc = crc_in;
    for (int b = 0; b < `SLINK_LINK_WIDTH / 8; b++) begin
      for (int i = 7; i >= 0; i--) begin
        fb  = crc[15] ^ word[8*b+i];
        crc = {crc[14:0], 1'b0};
        if (fb) begin
          crc = crc ^ `SLINK_CRC_POLY;
        end
      end
    end
    return crc;
  endfunction

  function automatic logic [7:0] hdr_check(input data_id_t id, input word_count_t wc);
    return id ^ wc[7:0] ^ wc[15:8];
  endfunction

endpackage

/* logic/slink_status_if.sv */
`timescale 1ns/1ns

interface slink_status_if;

  logic ll_enable;
  logic tx_pkt_sent;
  logic pkt_received;
  logic hdr_corrupted;
  logic crc_corrupted;

  modport regs (
    output ll_enable,
    input  tx_pkt_sent, pkt_received, hdr_corrupted, crc_corrupted
  );

  modport tx (input ll_enable, output tx_pkt_sent);

  modport rx (
    input  ll_enable,
    output pkt_received, hdr_corrupted, crc_corrupted
  );

endinterface

/* slink_lite.f */
+incdir+include
logic/slink_pkg.sv
logic/slink_status_if.sv
logic/slink_ll_tx.sv
logic/slink_ll_rx.sv
logic/slink_ctrl_regs.sv
logic/slink_lite.sv
tb/tb_clk_gen.sv
tb/tb_slink_checker.sv
tb/tb_slink_lite.sv

/* tb/slink_cases.txt */
// data_id word_count corrupt_idx xor_mask gap outcome, all hex, corrupt_idx ff means none
// outcome 0 good, 1 CRC error, 2 header error; frame word 0 is the header
12 0004 ff 00000000 0 0
2a 0000 ff 00000000 0 0
31 0008 ff 00000000 1 0
40 0003 02 00000100 0 1
55 0005 06 00000001 0 1
66 0004 00 00000001 0 2
67 0002 ff 00000000 0 0
70 0006 03 0000f000 1 1
81 0001 00 00010000 1 2
82 0007 ff 00000000 1 0
93 000a ff 00000000 0 0
a4 0000 ff 00000000 1 0
b5 0003 01 80000000 0 1
c6 0002 ff 00000000 0 0

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* tb/tb_slink_checker.sv */
`timescale 1ns/1ns
`include "slink_macros.svh"

module tb_slink_checker (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   tx_sop,
  input  slink_pkg::data_id_t    tx_data_id,
  input  slink_pkg::word_count_t tx_word_count,
  input  slink_pkg::link_word_t  tx_app_data,
  input  logic                   tx_advance,
  input  slink_pkg::link_word_t  phy_tx_data,
  input  logic                   phy_tx_valid,
  input  logic                   rx_sop,
  input  slink_pkg::data_id_t    rx_data_id,
  input  slink_pkg::word_count_t rx_word_count,
  input  slink_pkg::link_word_t  rx_app_data,
  input  logic                   rx_valid,
  input  logic                   rx_crc_corrupted,
  input  logic [1:0]             case_outcome,
  output int                     error_count,
  output int                     crc_pulses,
  output int                     outstanding
);

  slink_pkg::link_word_t  adv_q[$];
  slink_pkg::link_word_t  exp_data_q[$];
  slink_pkg::data_id_t    exp_id_q[$];
  slink_pkg::word_count_t exp_wc_q[$];
  logic [1:0]             exp_out_q[$];

  slink_pkg::data_id_t    sop_id;
  slink_pkg::word_count_t sop_wc;
  slink_pkg::data_id_t    fr_id;
  slink_pkg::word_count_t fr_wc;
  slink_pkg::crc_t        fr_crc;
  logic [1:0]             fr_out;
  logic [1:0]             rx_out;
  int                     tx_idx;
  int                     adv_cnt;

  initial begin
    error_count = 0;
    crc_pulses  = 0;
    outstanding = 0;
    tx_idx      = 0;
    adv_cnt     = 0;
    rx_out      = 2'd0;
  end

  task automatic flag_mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      error_count++;
    end
  endtask

  //--------------------------------------------------------------------
  // TX frame on the PHY side
  //--------------------------------------------------------------------
  task automatic take_frame_word();
    slink_pkg::link_word_t w;
    if (tx_idx == 0) begin
      fr_id  = sop_id;
      fr_wc  = sop_wc;
      fr_out = case_outcome;
      fr_crc = `SLINK_CRC_INIT;
      flag_mismatch("phy_tx_data[31:24]", phy_tx_data[31:24],
                    slink_pkg::hdr_check(fr_id, fr_wc));
      flag_mismatch("phy_tx_data[7:0]", phy_tx_data[7:0], fr_id);
      flag_mismatch("phy_tx_data[23:8]", phy_tx_data[23:8], fr_wc);
      if (fr_out != 2'd2) begin
        exp_id_q.push_back(fr_id);
        exp_wc_q.push_back(fr_wc);
        exp_out_q.push_back(fr_out);
      end
      tx_idx = 1;
    end else if (tx_idx <= int'(fr_wc)) begin
      if (adv_q.size() == 0) begin
        $display("Payload word %0d left the framer without tx_advance at %0t", tx_idx, $time);
        error_count++;
      end else begin
        w = adv_q.pop_front();
        flag_mismatch("phy_tx_data", phy_tx_data, w);
        fr_crc = slink_pkg::crc16_step(fr_crc, w);
        if (fr_out != 2'd2) begin
          exp_data_q.push_back(w);
        end
      end
      tx_idx++;
    end else begin
      flag_mismatch("phy_tx_data (crc)", phy_tx_data, {16'h0000, fr_crc});
      flag_mismatch("tx_advance count", adv_cnt, fr_wc);
      tx_idx = 0;
    end
  endtask

  // RX side against the frames sent
  task automatic take_rx_outputs();
    slink_pkg::link_word_t w;
    if (rx_sop) begin
      if (exp_id_q.size() == 0) begin
        $display("rx_sop for a packet that should not be delivered at %0t", $time);
        error_count++;
      end else begin
        flag_mismatch("rx_data_id", rx_data_id, exp_id_q.pop_front());
        flag_mismatch("rx_word_count", rx_word_count, exp_wc_q.pop_front());
        rx_out = exp_out_q.pop_front();
      end
    end
    if (rx_valid) begin
      if (exp_data_q.size() == 0) begin
        $display("rx_valid with no payload word outstanding at %0t", $time);
        error_count++;
      end else begin
        w = exp_data_q.pop_front();
        if (rx_out == 2'd0) begin
          flag_mismatch("rx_app_data", rx_app_data, w);
        end
      end
    end
    if (rx_crc_corrupted) begin
      crc_pulses++;
      if (rx_out != 2'd1) begin
        $display("rx_crc_corrupted on a packet that was sent intact at %0t", $time);
        error_count++;
      end
    end
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      if (tx_sop) begin
        sop_id  = tx_data_id;
        sop_wc  = tx_word_count;
        adv_cnt = 0;
        adv_q.delete();
      end
      if (tx_advance) begin
        adv_q.push_back(tx_app_data);
        adv_cnt++;
      end
      if (phy_tx_valid) begin
        take_frame_word();
      end
      take_rx_outputs();
      outstanding = exp_id_q.size() + exp_data_q.size();
    end
  end

endmodule

/* tb/tb_slink_lite.sv */
`timescale 1ns/1ns
`include "slink_macros.svh"

module tb_slink_lite;

  localparam int MAX_CASES = 32;

  logic                         clk;
  logic                         rst;
  logic [`SLINK_APB_ADDR_W-1:0] apb_paddr;
  logic                         apb_pwrite;
  logic                         apb_psel;
  logic                         apb_penable;
  logic [31:0]                  apb_pwdata;
  logic [31:0]                  apb_prdata;
  logic                         apb_pslverr;
  logic                         tx_sop;
  slink_pkg::data_id_t          tx_data_id;
  slink_pkg::word_count_t       tx_word_count;
  slink_pkg::link_word_t        tx_app_data;
  logic                         tx_advance;
  logic                         rx_sop;
  slink_pkg::data_id_t          rx_data_id;
  slink_pkg::word_count_t       rx_word_count;
  slink_pkg::link_word_t        rx_app_data;
  logic                         rx_valid;
  logic                         rx_crc_corrupted;
  logic                         interrupt;
  slink_pkg::link_word_t        phy_tx_data;
  logic                         phy_tx_valid;
  slink_pkg::link_word_t        phy_rx_data;
  logic                         phy_rx_valid;

  logic [31:0]           case_mem [0:6*MAX_CASES-1];
  slink_pkg::link_word_t pl_q[$];
  slink_pkg::link_word_t loop_q[$];
  logic [1:0]            case_outcome;
  int                    corrupt_idx;
  logic [31:0]           xor_mask;
  logic                  gap_en;
  int                    frame_idx;
  logic                  prev_tx_valid;
  int                    tb_errors;
  int                    chk_errors;
  int                    crc_pulses;
  int                    outstanding;
  longint                limit_ns;

  tb_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(3)) u_clk_gen (.clk(clk), .rst(rst));

  slink_lite u_dut (
    .link_clk         ( clk              ),
    .rst              ( rst              ),
    .apb_paddr        ( apb_paddr        ),
    .apb_pwrite       ( apb_pwrite       ),
    .apb_psel         ( apb_psel         ),
    .apb_penable      ( apb_penable      ),
    .apb_pwdata       ( apb_pwdata       ),
    .apb_prdata       ( apb_prdata       ),
    .apb_pslverr      ( apb_pslverr      ),
    .tx_sop           ( tx_sop           ),
    .tx_data_id       ( tx_data_id       ),
    .tx_word_count    ( tx_word_count    ),
    .tx_app_data      ( tx_app_data      ),
    .tx_advance       ( tx_advance       ),
    .rx_sop           ( rx_sop           ),
    .rx_data_id       ( rx_data_id       ),
    .rx_word_count    ( rx_word_count    ),
    .rx_app_data      ( rx_app_data      ),
    .rx_valid         ( rx_valid         ),
    .rx_crc_corrupted ( rx_crc_corrupted ),
    .interrupt        ( interrupt        ),
    .phy_tx_data      ( phy_tx_data      ),
    .phy_tx_valid     ( phy_tx_valid     ),
    .phy_rx_data      ( phy_rx_data      ),
    .phy_rx_valid     ( phy_rx_valid     )
  );

  tb_slink_checker u_checker (
    .clk              ( clk              ),
    .rst              ( rst              ),
    .tx_sop           ( tx_sop           ),
    .tx_data_id       ( tx_data_id       ),
    .tx_word_count    ( tx_word_count    ),
    .tx_app_data      ( tx_app_data      ),
    .tx_advance       ( tx_advance       ),
    .phy_tx_data      ( phy_tx_data      ),
    .phy_tx_valid     ( phy_tx_valid     ),
    .rx_sop           ( rx_sop           ),
    .rx_data_id       ( rx_data_id       ),
    .rx_word_count    ( rx_word_count    ),
    .rx_app_data      ( rx_app_data      ),
    .rx_valid         ( rx_valid         ),
    .rx_crc_corrupted ( rx_crc_corrupted ),
    .case_outcome     ( case_outcome     ),
    .error_count      ( chk_errors       ),
    .crc_pulses       ( crc_pulses       ),
    .outstanding      ( outstanding      )
  );

  //--------------------------------------------------------------------
  // Application payload and loopback with corruption and gaps
  //--------------------------------------------------------------------
  always @(negedge clk) begin
    if (tx_advance && pl_q.size() > 0) begin
      tx_app_data = pl_q.pop_front();
    end
  end

  always @(negedge clk) begin
    if (phy_tx_valid) begin
      if (!prev_tx_valid) begin
        frame_idx = 0;
      end
      loop_q.push_back((frame_idx == corrupt_idx) ? (phy_tx_data ^ xor_mask) : phy_tx_data);
      frame_idx++;
    end
    prev_tx_valid = phy_tx_valid;
    if (gap_en && phy_rx_valid) begin
      phy_rx_valid = 1'b0;
    end else if (loop_q.size() > 0) begin
      phy_rx_data  = loop_q.pop_front();
      phy_rx_valid = 1'b1;
    end else begin
      phy_rx_valid = 1'b0;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      tb_errors++;
    end
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    @(negedge clk);
    apb_paddr   = addr;
    apb_pwrite  = 1'b1;
    apb_psel    = 1'b1;
    apb_penable = 1'b0;
    apb_pwdata  = data;
    @(negedge clk);
    apb_penable = 1'b1;
    @(negedge clk);
    apb_psel    = 1'b0;
    apb_penable = 1'b0;
    apb_pwrite  = 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data, output logic err);
    @(negedge clk);
    apb_paddr   = addr;
    apb_pwrite  = 1'b0;
    apb_psel    = 1'b1;
    apb_penable = 1'b0;
    @(negedge clk);
    apb_penable = 1'b1;
    @(posedge clk);
    data = apb_prdata;
    err  = apb_pslverr;
    @(negedge clk);
    apb_psel    = 1'b0;
    apb_penable = 1'b0;
  endtask

  // Header-error frames need payload and CRC words that never look like a header
  task automatic make_payload(input slink_pkg::word_count_t wc, input logic [1:0] outcome);
    slink_pkg::link_word_t w;
    slink_pkg::crc_t       c;
    logic                  ok;
    int                    k;
    ok = 1'b0;
    while (!ok) begin
      pl_q.delete();
      c  = `SLINK_CRC_INIT;
      ok = 1'b1;
      for (k = 0; k < int'(wc); k++) begin
        w = $urandom;
        if (outcome == 2'd2 && slink_pkg::hdr_check(w[7:0], w[23:8]) == w[31:24]) begin
          ok = 1'b0;
        end
        pl_q.push_back(w);
        c = slink_pkg::crc16_step(c, w);
      end
      if (outcome == 2'd2 && c[7:0] == c[15:8]) begin
        ok = 1'b0;
      end
    end
  endtask

  task automatic send_packet(input slink_pkg::data_id_t id, input slink_pkg::word_count_t wc);
    @(negedge clk);
    tx_data_id    = id;
    tx_word_count = wc;
    tx_sop        = 1'b1;
    @(negedge clk);
    tx_sop = 1'b0;
  endtask

  task automatic wait_packet_done(input slink_pkg::word_count_t wc);
    int   n;
    int   limit;
    logic seen;
    n     = 0;
    seen  = 1'b0;
    limit = 4 * (int'(wc) + 2) + 20;
    while (n < limit && !(seen && !phy_tx_valid)) begin
      @(posedge clk);
      n++;
      if (phy_tx_valid) begin
        seen = 1'b1;
      end
    end
    while (n < limit && (loop_q.size() > 0 || phy_rx_valid)) begin
      @(posedge clk);
      n++;
    end
    if (n >= limit) begin
      $display("Timed out waiting for a frame of %0d words to pass the loopback", wc);
      tb_errors++;
    end
    repeat (2) @(posedge clk);
  endtask

  initial begin
    int                     i;
    int                     num_cases;
    int                     sent;
    int                     delivered;
    int                     crc_cases;
    longint                 words;
    logic [31:0]            rdata;
    logic                   rerr;
    logic [1:0]             cout;
    slink_pkg::word_count_t cwc;
    logic [2:0]             exp_status;

    apb_paddr     = '0;
    apb_pwrite    = 1'b0;
    apb_psel      = 1'b0;
    apb_penable   = 1'b0;
    apb_pwdata    = '0;
    tx_sop        = 1'b0;
    tx_data_id    = '0;
    tx_word_count = '0;
    tx_app_data   = '0;
    phy_rx_data   = '0;
    phy_rx_valid  = 1'b0;
    case_outcome  = 2'd0;
    corrupt_idx   = -1;
    xor_mask      = '0;
    gap_en        = 1'b0;
    frame_idx     = 0;
    prev_tx_valid = 1'b0;
    tb_errors     = 0;
    limit_ns      = 0;
    sent          = 0;
    delivered     = 0;
    crc_cases     = 0;
    void'($urandom(32'he616_09cd));

    $readmemh("tb/slink_cases.txt", case_mem);
    num_cases = 0;
    words     = 0;
    while (num_cases < MAX_CASES && !$isunknown(case_mem[6*num_cases])) begin
      words += case_mem[6*num_cases+1][15:0] + 2;
      num_cases++;
    end
    limit_ns = 40 * (words + 20 * num_cases + 200);

    while (rst) @(negedge clk);
    check_value("interrupt", {31'd0, interrupt}, 32'd0);

    read_reg(8'h14, rdata, rerr);
    check_value("apb_prdata (unmapped)", rdata, 32'd0);
    check_value("apb_pslverr (unmapped)", {31'd0, rerr}, 32'd1);
    read_reg(`SLINK_REG_CTRL, rdata, rerr);
    check_value("apb_prdata (ctrl)", rdata, 32'd0);
    check_value("apb_pslverr (ctrl)", {31'd0, rerr}, 32'd0);

    // Link disabled, no frame may come out
    send_packet(8'h5a, 16'd2);
    repeat (10) begin
      @(posedge clk);
      if (phy_tx_valid) begin
        $display("Frame sent while the link was disabled at %0t", $time);
        tb_errors++;
      end
    end

    write_reg(`SLINK_REG_CTRL, 32'd1);
    write_reg(`SLINK_REG_INT_EN, 32'd3);

    for (i = 0; i < num_cases; i++) begin
      cwc  = case_mem[6*i+1][15:0];
      cout = case_mem[6*i+5][1:0];
      make_payload(cwc, cout);
      corrupt_idx  = int'(case_mem[6*i+2][7:0]);
      xor_mask     = case_mem[6*i+3];
      gap_en       = case_mem[6*i+4][0];
      case_outcome = cout;
      send_packet(case_mem[6*i][7:0], cwc);
      wait_packet_done(cwc);
      sent++;
      if (cout != 2'd2) begin
        delivered++;
      end
      if (cout == 2'd1) begin
        crc_cases++;
      end
      if (outstanding != 0) begin
        $display("Packet %0d left %0d RX items undelivered at %0t", i, outstanding, $time);
        tb_errors++;
      end
      check_value("rx_crc_corrupted pulses", crc_pulses, crc_cases);
      exp_status = (cout == 2'd0) ? 3'b100 : (cout == 2'd1) ? 3'b101 : 3'b010;
      read_reg(`SLINK_REG_INT_STATUS, rdata, rerr);
      check_value("int_status", rdata, {29'd0, exp_status});
      check_value("interrupt", {31'd0, interrupt}, {31'd0, cout != 2'd0});
      write_reg(`SLINK_REG_INT_STATUS, 32'd7);
      read_reg(`SLINK_REG_INT_STATUS, rdata, rerr);
      check_value("int_status (cleared)", rdata, 32'd0);
      check_value("interrupt (cleared)", {31'd0, interrupt}, 32'd0);
    end

    read_reg(`SLINK_REG_RX_COUNT, rdata, rerr);
    check_value("rx_count", rdata, delivered);
    read_reg(`SLINK_REG_TX_COUNT, rdata, rerr);
    check_value("tx_count", rdata, sent);

    $display("Checks done with %0d errors (checker %0d, testbench %0d)",
             chk_errors + tb_errors, chk_errors, tb_errors);
    if (chk_errors + tb_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog sized from the case list
  initial begin
    wait (limit_ns > 0);
    #(limit_ns);
    $display("Watchdog expired after %0d ns before all cases finished", limit_ns);
    $display("Simulation failed");
    $finish;
  end

endmodule
